// File: rtl/icache_pkg.sv
// ###############################################
// Instruction cache geometry constants, field
// types and the controller state encoding
// ###############################################
package icache_pkg;

    // ###############################################
    // Geometry

    // Program counter width
    localparam int unsigned PC_WIDTH       = 8;
    // Threads per warp
    localparam int unsigned WARP_WIDTH     = 32;
    // Warps per compute unit
    localparam int unsigned NUM_WARPS      = 8;
    // Encoded instruction width
    localparam int unsigned ENC_INST_WIDTH = 4;
    // Word index bits, 4 words per line
    localparam int unsigned LINE_IDX_BITS  = 2;
    // Lines in the cache
    localparam int unsigned NUM_LINES      = 8;

    // Derived widths
    // PC = {tag, line select, word index}
    localparam int unsigned LINE_SEL_BITS  = $clog2(NUM_LINES);
    localparam int unsigned TAG_BITS       = PC_WIDTH - LINE_IDX_BITS - LINE_SEL_BITS;
    localparam int unsigned LINE_ADDR_BITS = PC_WIDTH - LINE_IDX_BITS;

    // ###############################################
    // Field types

    typedef logic [PC_WIDTH-1:0]            pc_t;
    typedef logic [WARP_WIDTH-1:0]          act_mask_t;
    typedef logic [$clog2(NUM_WARPS)-1:0]   wid_t;
    typedef logic [$clog2(WARP_WIDTH)-1:0]  subwarp_id_t;
    typedef logic [ENC_INST_WIDTH-1:0]      enc_inst_t;

    // One line, word 0 in the low bits
    typedef enc_inst_t [(1 << LINE_IDX_BITS)-1:0] line_data_t;

    // Memory line address, PC without word index
    typedef logic [LINE_ADDR_BITS-1:0]      line_addr_t;
    typedef logic [LINE_SEL_BITS-1:0]       line_sel_t;
    typedef logic [TAG_BITS-1:0]            line_tag_t;

    // ###############################################
    // Controller states

    typedef enum logic [1:0] {
        // Waiting for a fetch request
        IDLE     = 2'd0,
        // Lookup registered, hit or miss decided here
        LOOKUP   = 2'd1,
        // Line request sent, waiting for the response
        WAIT_MEM = 2'd2,
        // Refilled word held for the decoder
        WAIT_DEC = 2'd3
    } icache_state_e;

endpackage : icache_pkg

// File: rtl/icache_req_reg.sv
// ###############################################
// Active fetch request register and sticky flush flag
// ###############################################
`timescale 1ns/1ps

module icache_req_reg (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    // Request accepted this cycle
    input  logic                     accept_i,
    input  icache_pkg::pc_t          fe_pc_i,
    input  icache_pkg::act_mask_t    fe_act_mask_i,
    input  icache_pkg::wid_t         fe_warp_id_i,
    input  icache_pkg::subwarp_id_t  fe_subwarp_id_i,
    // Flush request and its service
    input  logic                     flush_i,
    input  logic                     flush_done_i,
    // Active request fields
    output icache_pkg::pc_t          req_pc_o,
    output icache_pkg::act_mask_t    req_act_mask_o,
    output icache_pkg::wid_t         req_warp_id_o,
    output icache_pkg::subwarp_id_t  req_subwarp_id_o,
    output logic                     flush_pending_o
);
    import icache_pkg::*;

    pc_t         pc_q;
    act_mask_t   act_mask_q;
    wid_t        warp_id_q;
    subwarp_id_t subwarp_id_q;
    logic        flush_q;

    // Request payload, held until the next acceptance
    always_ff @(posedge clk_i) begin
        if (accept_i) begin
            pc_q         <= fe_pc_i;
            act_mask_q   <= fe_act_mask_i;
            warp_id_q    <= fe_warp_id_i;
            subwarp_id_q <= fe_subwarp_id_i;
        end
    end

    // Sticky flush, a fresh pulse beats a clear
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            flush_q <= 1'b0;
        end else if (flush_i) begin
            flush_q <= 1'b1;
        end else if (flush_done_i) begin
            flush_q <= 1'b0;
        end
    end

    assign req_pc_o         = pc_q;
    assign req_act_mask_o   = act_mask_q;
    assign req_warp_id_o    = warp_id_q;
    assign req_subwarp_id_o = subwarp_id_q;
    assign flush_pending_o  = flush_q;

endmodule : icache_req_reg

// File: rtl/icache_line_store.sv
// ###############################################
// Tag and data arrays, valid bits, registered
// lookup and hit check of the direct-mapped cache
// ###############################################
`timescale 1ns/1ps

module icache_line_store (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    // Lookup issue
    input  logic                     accept_i,
    input  icache_pkg::pc_t          fe_pc_i,
    // Active request, used for compare and refill
    input  icache_pkg::pc_t          req_pc_i,
    // Refill write
    input  logic                     refill_i,
    input  icache_pkg::line_data_t   mem_data_i,
    // Invalidate everything
    input  logic                     flush_done_i,
    // Lookup result
    output logic                     hit_o,
    output icache_pkg::enc_inst_t    hit_inst_o
);
    import icache_pkg::*;

    // ###############################################
    // Storage

    line_tag_t  tag_mem_q  [NUM_LINES];
    line_data_t data_mem_q [NUM_LINES];
    logic [NUM_LINES-1:0] valid_q;

    // Lookup output registers
    line_tag_t  rd_tag_q;
    line_data_t rd_data_q;
    logic       rd_valid_q;

    // Index and tag fields
    line_sel_t  rd_sel;
    line_sel_t  wr_sel;
    line_tag_t  req_tag;

    // Lookup indexes with the incoming PC
    assign rd_sel  = fe_pc_i[LINE_IDX_BITS +: LINE_SEL_BITS];
    // Refill and compare use the held request
    assign wr_sel  = req_pc_i[LINE_IDX_BITS +: LINE_SEL_BITS];
    assign req_tag = req_pc_i[PC_WIDTH-1 -: TAG_BITS];

    // ###############################################
    // Array write and read

    // Refill writes tag and data of one line
    always_ff @(posedge clk_i) begin
        if (refill_i) begin
            tag_mem_q[wr_sel]  <= req_tag;
            data_mem_q[wr_sel] <= mem_data_i;
        end
    end

    // One cycle read latency, like a synchronous SRAM
    always_ff @(posedge clk_i) begin
        if (accept_i) begin
            rd_tag_q  <= tag_mem_q[rd_sel];
            rd_data_q <= data_mem_q[rd_sel];
        end
    end

    // Valid bits
    // Set on refill, flush clears all of them
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (flush_done_i) begin
            valid_q <= '0;
        end else if (refill_i) begin
            valid_q[wr_sel] <= 1'b1;
        end
    end

    // Valid bit of the looked-up line
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_valid_q <= 1'b0;
        end else if (accept_i) begin
            rd_valid_q <= valid_q[rd_sel];
        end
    end

    // ###############################################
    // Hit check

    // Meaningful in LOOKUP only
    assign hit_o      = rd_valid_q && (rd_tag_q == req_tag);
    // Requested word out of the registered line
    assign hit_inst_o = rd_data_q[req_pc_i[LINE_IDX_BITS-1:0]];

endmodule : icache_line_store

// File: rtl/icache_ctrl.sv
// ###############################################
// Cache controller FSM, memory refill request,
// refill buffer and decoder output
// ###############################################
`timescale 1ns/1ps

module icache_ctrl (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    // Fetcher handshake
    input  logic                     fe_valid_i,
    output logic                     ic_ready_o,
    output logic                     accept_o,
    // Flush
    input  logic                     flush_pending_i,
    output logic                     flush_done_o,
    // Lookup result
    input  logic                     hit_i,
    input  icache_pkg::enc_inst_t    hit_inst_i,
    // Active request
    input  icache_pkg::pc_t          req_pc_i,
    input  icache_pkg::act_mask_t    req_act_mask_i,
    input  icache_pkg::wid_t         req_warp_id_i,
    input  icache_pkg::subwarp_id_t  req_subwarp_id_i,
    // Memory port
    input  logic                     mem_ready_i,
    output logic                     mem_req_o,
    output icache_pkg::line_addr_t   mem_addr_o,
    input  logic                     mem_valid_i,
    input  icache_pkg::line_data_t   mem_data_i,
    output logic                     refill_o,
    // Decoder port
    input  logic                     dec_ready_i,
    output logic                     ic_valid_o,
    output icache_pkg::pc_t          ic_pc_o,
    output icache_pkg::act_mask_t    ic_act_mask_o,
    output icache_pkg::wid_t         ic_warp_id_o,
    output icache_pkg::subwarp_id_t  ic_subwarp_id_o,
    output icache_pkg::enc_inst_t    ic_inst_o
);
    import icache_pkg::*;

    icache_state_e state_q, state_d;
    line_data_t    refill_buf_q;
    logic          out_valid;
    enc_inst_t     out_inst;

    // ###############################################
    // Next state and handshakes

    always_comb begin
        state_d      = state_q;
        ic_ready_o   = 1'b0;
        flush_done_o = 1'b0;
        mem_req_o    = 1'b0;
        refill_o     = 1'b0;
        out_valid    = 1'b0;
        out_inst     = '0;

        case (state_q)
            IDLE: begin
                // Acceptance handled below
                state_d = IDLE;
            end
            LOOKUP: begin
                if (hit_i) begin
                    out_valid = 1'b1;
                    out_inst  = hit_inst_i;
                end else begin
                    // Miss, hold the request until memory takes it
                    mem_req_o = 1'b1;
                    if (mem_ready_i) begin
                        state_d = WAIT_MEM;
                    end
                end
            end
            WAIT_MEM: begin
                // Variable latency, ended by the response pulse
                refill_o = mem_valid_i;
                if (mem_valid_i) begin
                    state_d = WAIT_DEC;
                end
            end
            WAIT_DEC: begin
                out_valid = 1'b1;
                out_inst  = refill_buf_q[req_pc_i[LINE_IDX_BITS-1:0]];
            end
            default: begin
                state_d = IDLE;
            end
        endcase

        // Free slot in IDLE or on a decoder transfer
        if (state_q == IDLE || (out_valid && dec_ready_i)) begin
            if (flush_pending_i) begin
                // Flush takes this cycle, no new request
                flush_done_o = 1'b1;
                state_d      = IDLE;
            end else begin
                ic_ready_o = 1'b1;
                state_d    = fe_valid_i ? LOOKUP : IDLE;
            end
        end
    end

    assign accept_o = ic_ready_o && fe_valid_i;

    // ###############################################
    // Registers

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Returned line, read out in WAIT_DEC
    always_ff @(posedge clk_i) begin
        if (refill_o) begin
            refill_buf_q <= mem_data_i;
        end
    end

    // Line address only while requesting
    assign mem_addr_o = mem_req_o ? req_pc_i[PC_WIDTH-1:LINE_IDX_BITS] : '0;

    // Decoder outputs, zero while not valid
    // Held stable since the request and lookup only move on accept
    assign ic_valid_o      = out_valid;
    assign ic_pc_o         = out_valid ? req_pc_i : '0;
    assign ic_act_mask_o   = out_valid ? req_act_mask_i : '0;
    assign ic_warp_id_o    = out_valid ? req_warp_id_i : '0;
    assign ic_subwarp_id_o = out_valid ? req_subwarp_id_i : '0;
    assign ic_inst_o       = out_inst;

endmodule : icache_ctrl

// File: rtl/icache_top.sv
// ###############################################
// Instruction cache top level with fetcher,
// memory and decoder ports
// ###############################################
`timescale 1ns/1ps

module icache_top (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    // Fetcher
    input  logic                     fe_valid_i,
    output logic                     ic_ready_o,
    input  icache_pkg::pc_t          fe_pc_i,
    input  icache_pkg::act_mask_t    fe_act_mask_i,
    input  icache_pkg::wid_t         fe_warp_id_i,
    input  icache_pkg::subwarp_id_t  fe_subwarp_id_i,
    // Memory
    input  logic                     mem_ready_i,
    output logic                     mem_req_o,
    output icache_pkg::line_addr_t   mem_addr_o,
    input  logic                     mem_valid_i,
    input  icache_pkg::line_data_t   mem_data_i,
    // Decoder
    input  logic                     dec_ready_i,
    output logic                     ic_valid_o,
    output icache_pkg::pc_t          ic_pc_o,
    output icache_pkg::act_mask_t    ic_act_mask_o,
    output icache_pkg::wid_t         ic_warp_id_o,
    output icache_pkg::subwarp_id_t  ic_subwarp_id_o,
    output icache_pkg::enc_inst_t    ic_inst_o
);
    import icache_pkg::*;

    // Internal handshakes
    logic        accept;
    logic        flush_pending;
    logic        flush_done;
    logic        refill;
    logic        hit;
    enc_inst_t   hit_inst;

    // Active request
    pc_t         req_pc;
    act_mask_t   req_act_mask;
    wid_t        req_warp_id;
    subwarp_id_t req_subwarp_id;

    icache_req_reg icache_req_reg_i (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .accept_i         (accept),
        .fe_pc_i          (fe_pc_i),
        .fe_act_mask_i    (fe_act_mask_i),
        .fe_warp_id_i     (fe_warp_id_i),
        .fe_subwarp_id_i  (fe_subwarp_id_i),
        .flush_i          (flush_i),
        .flush_done_i     (flush_done),
        .req_pc_o         (req_pc),
        .req_act_mask_o   (req_act_mask),
        .req_warp_id_o    (req_warp_id),
        .req_subwarp_id_o (req_subwarp_id),
        .flush_pending_o  (flush_pending)
    );

    icache_line_store icache_line_store_i (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .accept_i     (accept),
        .fe_pc_i      (fe_pc_i),
        .req_pc_i     (req_pc),
        .refill_i     (refill),
        .mem_data_i   (mem_data_i),
        .flush_done_i (flush_done),
        .hit_o        (hit),
        .hit_inst_o   (hit_inst)
    );

    icache_ctrl icache_ctrl_i (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .fe_valid_i       (fe_valid_i),
        .ic_ready_o       (ic_ready_o),
        .accept_o         (accept),
        .flush_pending_i  (flush_pending),
        .flush_done_o     (flush_done),
        .hit_i            (hit),
        .hit_inst_i       (hit_inst),
        .req_pc_i         (req_pc),
        .req_act_mask_i   (req_act_mask),
        .req_warp_id_i    (req_warp_id),
        .req_subwarp_id_i (req_subwarp_id),
        .mem_ready_i      (mem_ready_i),
        .mem_req_o        (mem_req_o),
        .mem_addr_o       (mem_addr_o),
        .mem_valid_i      (mem_valid_i),
        .mem_data_i       (mem_data_i),
        .refill_o         (refill),
        .dec_ready_i      (dec_ready_i),
        .ic_valid_o       (ic_valid_o),
        .ic_pc_o          (ic_pc_o),
        .ic_act_mask_o    (ic_act_mask_o),
        .ic_warp_id_o     (ic_warp_id_o),
        .ic_subwarp_id_o  (ic_subwarp_id_o),
        .ic_inst_o        (ic_inst_o)
    );

endmodule : icache_top

// File: tb/tb_icache.sv
// ##################################################
// Instruction cache testbench with a stimulus table,
// memory model, decoder model and typed compare tasks
// ##################################################
`timescale 1ns/1ps

module tb_icache;
    import icache_pkg::*;

    localparam int unsigned WAIT_MAX   = 64;
    localparam int unsigned NUM_ROWS   = 12;
    localparam int unsigned NUM_STREAM = 6;

    // One fetch with its expected memory behavior
    typedef struct {
        string       name;
        pc_t         pc;
        logic        flush;
        int unsigned stall;
        logic        miss;
    } row_t;

    logic        clk_i;
    logic        rst_ni;
    logic        flush_i;
    logic        fe_valid_i;
    logic        ic_ready_o;
    pc_t         fe_pc_i;
    act_mask_t   fe_act_mask_i;
    wid_t        fe_warp_id_i;
    subwarp_id_t fe_subwarp_id_i;
    logic        mem_ready_i;
    logic        mem_req_o;
    line_addr_t  mem_addr_o;
    logic        mem_valid_i;
    line_data_t  mem_data_i;
    logic        dec_ready_i;
    logic        ic_valid_o;
    pc_t         ic_pc_o;
    act_mask_t   ic_act_mask_o;
    wid_t        ic_warp_id_o;
    subwarp_id_t ic_subwarp_id_o;
    enc_inst_t   ic_inst_o;

    // Memory model state, shared with the stimulus
    int unsigned mem_req_count;
    line_addr_t  mem_req_addr;
    int unsigned mem_latency;
    logic        ready_stall;
    logic        ready_next;
    int unsigned value_errors;
    int unsigned other_errors;

    // Sel 5 alternates tags 0 and 1, row 9 flushes line 0
    row_t rows [NUM_ROWS] = '{
        '{"cold_line0",    8'h00, 1'b0, 0, 1'b1},
        '{"hit_same_pc",   8'h00, 1'b0, 0, 1'b0},
        '{"hit_word3",     8'h03, 1'b0, 2, 1'b0},
        '{"cold_sel5_t0",  8'h15, 1'b0, 0, 1'b1},
        '{"evict_sel5_t1", 8'h34, 1'b0, 0, 1'b1},
        '{"evict_sel5_t0", 8'h15, 1'b0, 0, 1'b1},
        '{"evict_again",   8'h36, 1'b0, 0, 1'b1},
        '{"stall_hit",     8'h37, 1'b0, 3, 1'b0},
        '{"stall_miss",    8'hA9, 1'b0, 4, 1'b1},
        '{"flush_refetch", 8'h00, 1'b1, 0, 1'b1},
        '{"hit_refilled",  8'h02, 1'b0, 1, 1'b0},
        '{"cold_top_line", 8'hFE, 1'b0, 0, 1'b1}
    };

    // All cached after the table
    pc_t stream_pc [NUM_STREAM] = '{8'h01, 8'h02, 8'hFC, 8'hFF, 8'h03, 8'h00};

    icache_top icache_top_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // ##################################################
    // Memory contents
    // Word k of line A is the low 4 bits of A*3 + k

    function automatic enc_inst_t model_inst(input pc_t pc);
        line_addr_t addr;
        addr = pc[PC_WIDTH-1:LINE_IDX_BITS];
        return enc_inst_t'(addr * 3 + pc[LINE_IDX_BITS-1:0]);
    endfunction

    function automatic line_data_t model_line(input line_addr_t addr);
        line_data_t line;
        for (int k = 0; k < (1 << LINE_IDX_BITS); k++) begin
            line[k] = enc_inst_t'(addr * 3 + k);
        end
        return line;
    endfunction

    // ##################################################
    // Memory model

    initial begin
        mem_ready_i   = 1'b1;
        mem_valid_i   = 1'b0;
        mem_data_i    = '0;
        mem_req_count = 0;
        mem_req_addr  = '0;
        forever begin
            @(negedge clk_i);
            if (mem_req_o && mem_ready_i) begin
                // Taken at the coming edge
                mem_req_count++;
                mem_req_addr = mem_addr_o;
                repeat (mem_latency) @(posedge clk_i);
                mem_valid_i <= 1'b1;
                mem_data_i  <= model_line(mem_req_addr);
                @(posedge clk_i);
                mem_valid_i <= 1'b0;
                mem_data_i  <= '0;
            end else if (mem_req_o) begin
                // Not ready for one cycle, then release
                @(posedge clk_i);
                mem_ready_i <= 1'b1;
            end else begin
                ready_next = !ready_stall;
                @(posedge clk_i);
                mem_ready_i <= ready_next;
            end
        end
    end

    // ##################################################
    // Compare tasks

    task automatic check_pc(input string name, input pc_t exp, input pc_t act);
        if (exp !== act) begin
            value_errors++;
            $display("ERR %s pc: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_mask(input string name, input act_mask_t exp, input act_mask_t act);
        if (exp !== act) begin
            value_errors++;
            $display("ERR %s act mask: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_wid(input string name, input wid_t exp, input wid_t act);
        if (exp !== act) begin
            value_errors++;
            $display("ERR %s warp id: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_swid(input string name, input subwarp_id_t exp,
                              input subwarp_id_t act);
        if (exp !== act) begin
            value_errors++;
            $display("ERR %s subwarp id: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_inst(input string name, input enc_inst_t exp, input enc_inst_t act);
        if (exp !== act) begin
            value_errors++;
            $display("ERR %s inst: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input line_addr_t exp,
                              input line_addr_t act);
        if (exp !== act) begin
            value_errors++;
            $display("ERR %s mem addr: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            value_errors++;
            $display("ERR %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic report_timeout(input string name, input string what);
        other_errors++;
        $display("Timeout in %s: no %s within %0d cycles", name, what, WAIT_MAX);
    endtask

    // Decoder side view of one delivered fetch
    task automatic check_outputs(input string name, input pc_t pc, input act_mask_t mask,
                                 input wid_t wid, input subwarp_id_t swid);
        check_flag({name, " valid"}, 1'b1, ic_valid_o);
        check_pc(name, pc, ic_pc_o);
        check_mask(name, mask, ic_act_mask_o);
        check_wid(name, wid, ic_warp_id_o);
        check_swid(name, swid, ic_subwarp_id_o);
        check_inst(name, model_inst(pc), ic_inst_o);
    endtask

    task automatic drive_request(input pc_t pc, input act_mask_t mask,
                                 input wid_t wid, input subwarp_id_t swid);
        fe_valid_i      <= 1'b1;
        fe_pc_i         <= pc;
        fe_act_mask_i   <= mask;
        fe_warp_id_i    <= wid;
        fe_subwarp_id_i <= swid;
    endtask

    // ##################################################
    // One table row, entered and left on a rising edge

    task automatic run_row(input row_t row, input logic stall_mem);
        act_mask_t   mask;
        wid_t        wid;
        subwarp_id_t swid;
        int unsigned base;
        int unsigned n;
        int unsigned s;
        mask        = $urandom();
        wid         = wid_t'($urandom());
        swid        = subwarp_id_t'($urandom());
        mem_latency = $urandom_range(4, 1);
        ready_stall = stall_mem;
        base        = mem_req_count;
        if (row.flush) begin
            flush_i <= 1'b1;
            @(posedge clk_i);
            flush_i <= 1'b0;
        end
        drive_request(row.pc, mask, wid, swid);
        dec_ready_i <= (row.stall == 0);
        n = 0;
        do begin
            @(negedge clk_i);
            n++;
        end while (!ic_ready_o && n < WAIT_MAX);
        if (!ic_ready_o) report_timeout(row.name, "ic_ready_o");
        // Acceptance edge
        @(posedge clk_i);
        fe_valid_i <= 1'b0;
        n = 0;
        do begin
            @(negedge clk_i);
            n++;
        end while (!ic_valid_o && n < WAIT_MAX);
        if (!ic_valid_o) report_timeout(row.name, "ic_valid_o");
        // Outputs must hold while the decoder stalls
        for (s = 0; s <= row.stall; s++) begin
            check_outputs(row.name, row.pc, mask, wid, swid);
            @(posedge clk_i);
            if (s + 1 == row.stall) dec_ready_i <= 1'b1;
            if (s < row.stall) @(negedge clk_i);
        end
        check_flag({row.name, " miss"}, row.miss, mem_req_count != base);
        if (row.miss && mem_req_count != base) begin
            check_addr(row.name, row.pc[PC_WIDTH-1:LINE_IDX_BITS], mem_req_addr);
        end
        if (mem_req_count - base > 1) begin
            other_errors++;
            $display("%s raised %0d memory requests for one miss", row.name,
                     mem_req_count - base);
        end
    endtask

    // ##################################################
    // Back-to-back hits, order checked

    task automatic run_stream();
        act_mask_t   mask [NUM_STREAM];
        wid_t        wid [NUM_STREAM];
        subwarp_id_t swid [NUM_STREAM];
        int unsigned base;
        int unsigned sent;
        int unsigned got;
        int unsigned n;
        logic        acc;
        for (int i = 0; i < NUM_STREAM; i++) begin
            mask[i] = $urandom();
            wid[i]  = wid_t'($urandom());
            swid[i] = subwarp_id_t'($urandom());
        end
        ready_stall = 1'b0;
        base        = mem_req_count;
        sent        = 0;
        got         = 0;
        n           = 0;
        drive_request(stream_pc[0], mask[0], wid[0], swid[0]);
        dec_ready_i <= 1'b1;
        while (got < NUM_STREAM && n < WAIT_MAX) begin
            @(negedge clk_i);
            n++;
            acc = ic_ready_o && fe_valid_i;
            if (ic_valid_o) begin
                check_outputs("stream", stream_pc[got], mask[got], wid[got], swid[got]);
                got++;
            end
            @(posedge clk_i);
            if (acc) begin
                sent++;
                if (sent < NUM_STREAM) begin
                    drive_request(stream_pc[sent], mask[sent], wid[sent], swid[sent]);
                end else begin
                    fe_valid_i <= 1'b0;
                end
            end
        end
        if (got < NUM_STREAM) report_timeout("stream", "full stream delivery");
        check_flag("stream miss", 1'b0, mem_req_count != base);
    endtask

    initial begin
        void'($urandom(32'h8c68d581));
        value_errors    = 0;
        other_errors    = 0;
        ready_stall     = 1'b0;
        rst_ni          = 1'b0;
        flush_i         = 1'b0;
        fe_valid_i      = 1'b0;
        fe_pc_i         = '0;
        fe_act_mask_i   = '0;
        fe_warp_id_i    = '0;
        fe_subwarp_id_i = '0;
        dec_ready_i     = 1'b1;
        repeat (10) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(posedge clk_i);
        // Even rows also hold mem_ready_i low for a cycle
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(rows[i], (i % 2) == 0);
        end
        run_stream();
        repeat (2) @(posedge clk_i);
        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule : tb_icache

// File: compile.f
rtl/icache_pkg.sv
rtl/icache_req_reg.sv
rtl/icache_line_store.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
tb/tb_icache.sv

// File: run.sh
#!/bin/sh
# Build and run the instruction cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module tb_icache -o tb_icache
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/tb_icache)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Regression passed$"; then
    exit 0
fi
exit 1
